//--- hdl/icache_params.svh
`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

// set index width, 16 sets
`define ICACHE_INDEX_W 4

// word offset width, four words per line
`define ICACHE_OFFSET_W 2

// number of sets
`define ICACHE_SETS (1 << `ICACHE_INDEX_W)

// address field positions (byte offset is two bits)
`define ICACHE_OFFSET_LSB 2
`define ICACHE_INDEX_LSB (`ICACHE_OFFSET_LSB + `ICACHE_OFFSET_W)
`define ICACHE_TAG_LSB (`ICACHE_INDEX_LSB + `ICACHE_INDEX_W)

`endif

//--- hdl/icache_pkg.sv
`include "icache_params.svh"

package icache_pkg;

    // instruction word or byte address
    typedef logic [31:0] word_t;

    // address fields
    typedef logic [31:`ICACHE_TAG_LSB] tag_t;
    typedef logic [`ICACHE_INDEX_W-1:0] index_t;
    typedef logic [`ICACHE_OFFSET_W-1:0] offset_t;

    // one line and one dual-issue word pair
    typedef logic [(32 << `ICACHE_OFFSET_W)-1:0] line_t;
    typedef logic [63:0] pair_t;

    // controller states
    typedef enum logic [1:0] {
        S_SWEEP,
        S_LOOKUP,
        S_MISS,
        S_REFILL
    } icache_state_t;

endpackage

//--- hdl/icache_fill_if.sv
`timescale 1ns/1ps

interface icache_fill_if import icache_pkg::*; ();

    index_t fill_index;
    tag_t   fill_tag;
    line_t  fill_line;
    logic   fill_way;
    logic   tag_we;
    logic   data_we;
    // invalidate both ways at fill_index
    logic   clear;

    modport ctrl (output fill_index, fill_tag, fill_line, fill_way, tag_we, data_we, clear);
    modport tag  (input fill_index, fill_tag, fill_way, tag_we, clear);
    modport data (input fill_index, fill_line, fill_way, data_we);

endinterface

//--- hdl/icache_req_buf.sv
`timescale 1ns/1ps
`include "icache_params.svh"

module icache_req_buf import icache_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    load,
    input  word_t   addr_in,
    output tag_t    tag,
    output index_t  index,
    output offset_t offset,
    output word_t   line_addr
);

    word_t addr_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            addr_q <= '0;
        end else if (load) begin
            addr_q <= addr_in;
        end
    end

    // split into fields
    assign tag    = addr_q[31:`ICACHE_TAG_LSB];
    assign index  = addr_q[`ICACHE_TAG_LSB-1:`ICACHE_INDEX_LSB];
    assign offset = addr_q[`ICACHE_INDEX_LSB-1:`ICACHE_OFFSET_LSB];

    // line aligned address for the memory bus
    assign line_addr = {addr_q[31:`ICACHE_INDEX_LSB], {`ICACHE_INDEX_LSB{1'b0}}};

endmodule

//--- hdl/icache_sweep_cnt.sv
`timescale 1ns/1ps
`include "icache_params.svh"

module icache_sweep_cnt import icache_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   start,
    output index_t index,
    output logic   busy,
    output logic   done
);

    assign done = busy && (index == index_t'(`ICACHE_SETS - 1));

    // reset behaves like a start
    always_ff @(posedge clk) begin
        if (rst || start) begin
            index <= '0;
            busy  <= 1'b1;
        end else if (busy) begin
            index <= index + 1'b1;
            busy  <= !done;
        end
    end

endmodule

//--- hdl/icache_tag_store.sv
`timescale 1ns/1ps
`include "icache_params.svh"

module icache_tag_store import icache_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  index_t      rd_index,
    input  tag_t        cmp_tag,
    output logic        hit_way,
    output logic        hit,
    icache_fill_if.tag  fill
);

    tag_t tags0 [`ICACHE_SETS];
    tag_t tags1 [`ICACHE_SETS];
    logic [`ICACHE_SETS-1:0] valid0;
    logic [`ICACHE_SETS-1:0] valid1;

    tag_t rd_tag0;
    tag_t rd_tag1;
    logic rd_valid0;
    logic rd_valid1;
    logic hit0;
    logic hit1;

    // synchronous read
    always_ff @(posedge clk) begin
        rd_tag0 <= tags0[rd_index];
        rd_tag1 <= tags1[rd_index];
        if (rst) begin
            rd_valid0 <= 1'b0;
            rd_valid1 <= 1'b0;
        end else begin
            rd_valid0 <= valid0[rd_index];
            rd_valid1 <= valid1[rd_index];
        end
    end

    // clear wins over a tag write
    always_ff @(posedge clk) begin
        if (fill.clear) begin
            valid0[fill.fill_index] <= 1'b0;
            valid1[fill.fill_index] <= 1'b0;
        end else if (fill.tag_we) begin
            if (fill.fill_way) begin
                tags1[fill.fill_index]  <= fill.fill_tag;
                valid1[fill.fill_index] <= 1'b1;
            end else begin
                tags0[fill.fill_index]  <= fill.fill_tag;
                valid0[fill.fill_index] <= 1'b1;
            end
        end
    end

    assign hit0    = rd_valid0 && (rd_tag0 == cmp_tag);
    assign hit1    = rd_valid1 && (rd_tag1 == cmp_tag);
    assign hit     = hit0 || hit1;
    assign hit_way = hit1;

endmodule

//--- hdl/icache_data_store.sv
`timescale 1ns/1ps
`include "icache_params.svh"

module icache_data_store import icache_pkg::*; (
    input  logic        clk,
    input  index_t      rd_index,
    input  logic        way_sel,
    input  logic        use_refill,
    input  line_t       refill_line,
    input  offset_t     offset,
    output pair_t       rdata,
    output logic        pair_ok,
    icache_fill_if.data fill
);

    line_t lines [2][`ICACHE_SETS];
    line_t rd_line0;
    line_t rd_line1;
    line_t sel_line;
    word_t lo_word;
    word_t hi_word;

    always_ff @(posedge clk) begin
        if (fill.data_we) begin
            lines[fill.fill_way][fill.fill_index] <= fill.fill_line;
        end
        rd_line0 <= lines[0][rd_index];
        rd_line1 <= lines[1][rd_index];
    end

    assign sel_line = use_refill ? refill_line : (way_sel ? rd_line1 : rd_line0);

    // pair only inside an aligned doubleword
    assign lo_word = sel_line[{offset, 5'd0} +: 32];
    assign hi_word = sel_line[{offset[1], 1'b1, 5'd0} +: 32];
    assign pair_ok = !offset[0];
    assign rdata   = {pair_ok ? hi_word : 32'd0, lo_word};

endmodule

//--- hdl/icache_lru.sv
`timescale 1ns/1ps
`include "icache_params.svh"

module icache_lru import icache_pkg::*; (
    input  logic        clk,
    input  logic        touch,
    input  index_t      touch_index,
    input  logic        touch_way,
    input  index_t      victim_index,
    output logic        victim,
    icache_fill_if.tag  fill
);

    // bit names the least recently used way
    logic [`ICACHE_SETS-1:0] lru_bits;

    always_ff @(posedge clk) begin
        if (fill.clear) begin
            lru_bits[fill.fill_index] <= 1'b0;
        end else if (touch) begin
            lru_bits[touch_index] <= !touch_way;
        end
    end

    assign victim = lru_bits[victim_index];

endmodule

//--- hdl/icache_ctrl_fsm.sv
`timescale 1ns/1ps

module icache_ctrl_fsm import icache_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  logic          flush,
    input  logic          fetch_valid,
    output logic          fetch_ready,
    output logic          rdata_valid,
    input  logic          hit,
    input  logic          hit_way,
    input  logic          victim,
    output logic          buf_load,
    output logic          use_refill,
    output logic          way_sel,
    output logic          touch,
    output logic          touch_way,
    output logic          mem_req,
    input  logic          mem_addr_ok,
    input  logic          mem_data_ok,
    input  line_t         mem_line,
    input  tag_t          line_tag,
    input  index_t        line_index,
    output logic          sweep_start,
    input  logic          sweep_busy,
    input  logic          sweep_done,
    input  index_t        sweep_index,
    icache_fill_if.ctrl   fill
);

    icache_state_t state;
    icache_state_t state_next;
    // a request was accepted in the previous cycle
    logic pend;
    logic lookup_hit;
    logic lookup_miss;
    logic refill_done;

    assign lookup_hit  = (state == S_LOOKUP) && pend && hit;
    assign lookup_miss = (state == S_LOOKUP) && pend && !hit;
    assign refill_done = (state == S_REFILL) && mem_data_ok;

    //////////////////////////////////////////////////
    // fetch side
    //////////////////////////////////////////////////

    // flush only counts when idle in lookup
    always_comb begin
        fetch_ready = 1'b0;
        if (state == S_LOOKUP) begin
            fetch_ready = pend ? hit : !flush;
        end
    end

    assign buf_load    = fetch_valid && fetch_ready;
    assign sweep_start = (state == S_LOOKUP) && !pend && flush;
    assign rdata_valid = lookup_hit || refill_done;

    // refill line bypasses the arrays
    assign use_refill = (state == S_REFILL);
    assign way_sel    = hit_way;
    assign touch      = lookup_hit || refill_done;
    assign touch_way  = use_refill ? victim : hit_way;

    // request goes out in the miss cycle itself
    assign mem_req = (state == S_MISS) || lookup_miss;

    //////////////////////////////////////////////////
    // array write port
    //////////////////////////////////////////////////

    assign fill.clear      = (state == S_SWEEP) && sweep_busy;
    assign fill.fill_index = fill.clear ? sweep_index : line_index;
    assign fill.fill_tag   = line_tag;
    assign fill.fill_line  = mem_line;
    assign fill.fill_way   = victim;
    assign fill.tag_we     = refill_done;
    assign fill.data_we    = refill_done;

    //////////////////////////////////////////////////
    // state machine
    //////////////////////////////////////////////////

    always_comb begin
        state_next = state;
        case (state)
            S_SWEEP: begin
                if (sweep_done) begin
                    state_next = S_LOOKUP;
                end
            end
            S_LOOKUP: begin
                if (lookup_miss) begin
                    state_next = mem_addr_ok ? S_REFILL : S_MISS;
                end else if (sweep_start) begin
                    state_next = S_SWEEP;
                end
            end
            S_MISS: begin
                if (mem_addr_ok) begin
                    state_next = S_REFILL;
                end
            end
            S_REFILL: begin
                if (mem_data_ok) begin
                    state_next = S_LOOKUP;
                end
            end
            default: state_next = S_SWEEP;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_SWEEP;
            pend  <= 1'b0;
        end else begin
            state <= state_next;
            pend  <= buf_load;
        end
    end

endmodule

//--- hdl/icache_top.sv
`timescale 1ns/1ps
`include "icache_params.svh"

module icache_top import icache_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  fetch_valid,
    input  word_t fetch_addr,
    input  logic  flush,
    output logic  fetch_ready,
    output logic  rdata_valid,
    output pair_t rdata,
    output logic  pair_ok,
    output logic  mem_req,
    output word_t mem_addr,
    input  logic  mem_addr_ok,
    input  logic  mem_data_ok,
    input  line_t mem_line
);

    index_t  rd_index;
    tag_t    buf_tag;
    index_t  buf_index;
    offset_t buf_offset;
    index_t  sweep_index;
    logic    sweep_start;
    logic    sweep_busy;
    logic    sweep_done;
    logic    hit;
    logic    hit_way;
    logic    victim;
    logic    buf_load;
    logic    use_refill;
    logic    way_sel;
    logic    touch;
    logic    touch_way;

    icache_fill_if u_fill ();

    // arrays are read with the incoming index
    assign rd_index = fetch_addr[`ICACHE_TAG_LSB-1:`ICACHE_INDEX_LSB];

    icache_req_buf u_req_buf (
        .clk       (clk),
        .rst       (rst),
        .load      (buf_load),
        .addr_in   (fetch_addr),
        .tag       (buf_tag),
        .index     (buf_index),
        .offset    (buf_offset),
        .line_addr (mem_addr)
    );

    icache_sweep_cnt u_sweep_cnt (
        .clk   (clk),
        .rst   (rst),
        .start (sweep_start),
        .index (sweep_index),
        .busy  (sweep_busy),
        .done  (sweep_done)
    );

    icache_tag_store u_tag_store (
        .clk      (clk),
        .rst      (rst),
        .rd_index (rd_index),
        .cmp_tag  (buf_tag),
        .hit_way  (hit_way),
        .hit      (hit),
        .fill     (u_fill.tag)
    );

    icache_data_store u_data_store (
        .clk         (clk),
        .rd_index    (rd_index),
        .way_sel     (way_sel),
        .use_refill  (use_refill),
        .refill_line (mem_line),
        .offset      (buf_offset),
        .rdata       (rdata),
        .pair_ok     (pair_ok),
        .fill        (u_fill.data)
    );

    icache_lru u_lru (
        .clk          (clk),
        .touch        (touch),
        .touch_index  (buf_index),
        .touch_way    (touch_way),
        .victim_index (buf_index),
        .victim       (victim),
        .fill         (u_fill.tag)
    );

    icache_ctrl_fsm u_ctrl_fsm (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .fetch_valid (fetch_valid),
        .fetch_ready (fetch_ready),
        .rdata_valid (rdata_valid),
        .hit         (hit),
        .hit_way     (hit_way),
        .victim      (victim),
        .buf_load    (buf_load),
        .use_refill  (use_refill),
        .way_sel     (way_sel),
        .touch       (touch),
        .touch_way   (touch_way),
        .mem_req     (mem_req),
        .mem_addr_ok (mem_addr_ok),
        .mem_data_ok (mem_data_ok),
        .mem_line    (mem_line),
        .line_tag    (buf_tag),
        .line_index  (buf_index),
        .sweep_start (sweep_start),
        .sweep_busy  (sweep_busy),
        .sweep_done  (sweep_done),
        .sweep_index (sweep_index),
        .fill        (u_fill.ctrl)
    );

endmodule

//--- tb/icache_assertions.sv
`timescale 1ns/1ps

module icache_assertions import icache_pkg::*; (
    input logic  clk,
    input logic  rst,
    input logic  fetch_valid,
    input word_t fetch_addr,
    input logic  fetch_ready,
    input logic  rdata_valid,
    input logic  pair_ok,
    input logic  mem_req,
    input word_t mem_addr,
    input logic  mem_addr_ok,
    input logic  mem_data_ok
);

    int fail_count = 0;
    // offset bit 0 of the last accepted request
    logic acc_odd;

    always_ff @(posedge clk) begin
        if (rst) begin
            acc_odd <= 1'b0;
        end else if (fetch_valid && fetch_ready) begin
            acc_odd <= fetch_addr[2];
        end
    end

    addr_stable: assert property (@(posedge clk) disable iff (rst)
        mem_req && !mem_addr_ok |=> $stable(mem_addr))
        else begin
            $error("mem_addr changed while waiting for mem_addr_ok");
            fail_count++;
        end

    // only the refill strobe may return data while stalled
    valid_when_ready: assert property (@(posedge clk) disable iff (rst)
        rdata_valid && !fetch_ready |-> mem_data_ok)
        else begin
            $error("rdata_valid high with fetch_ready low outside mem_data_ok");
            fail_count++;
        end

    no_pair_odd: assert property (@(posedge clk) disable iff (rst)
        rdata_valid && acc_odd |-> !pair_ok)
        else begin
            $error("pair_ok high for an odd word offset");
            fail_count++;
        end

endmodule

bind icache_top icache_assertions u_icache_assertions (
    .clk         (clk),
    .rst         (rst),
    .fetch_valid (fetch_valid),
    .fetch_addr  (fetch_addr),
    .fetch_ready (fetch_ready),
    .rdata_valid (rdata_valid),
    .pair_ok     (pair_ok),
    .mem_req     (mem_req),
    .mem_addr    (mem_addr),
    .mem_addr_ok (mem_addr_ok),
    .mem_data_ok (mem_data_ok)
);

//--- tb/icache_tb.sv
`timescale 1ns/1ps

module icache_tb import icache_pkg::*; ();

    localparam int NUM_STIM = 15;

    typedef struct packed {
        logic [2:0] test_no;
        logic       flush_first;
        logic       exp_miss;
        word_t      addr;
    } stim_t;

    logic  clk;
    logic  rst;
    logic  fetch_valid;
    word_t fetch_addr;
    logic  flush;
    logic  fetch_ready;
    logic  rdata_valid;
    pair_t rdata;
    logic  pair_ok;
    logic  mem_req;
    word_t mem_addr;
    logic  mem_addr_ok;
    logic  mem_data_ok;
    line_t mem_line;

    stim_t stim_table [NUM_STIM];
    string test_names [1:5];
    int    errors;
    int    test_start_errs;
    int    tests_run;
    int    tests_failed;
    logic  timed_out;

    icache_top u_icache_top (
        .clk         (clk),
        .rst         (rst),
        .fetch_valid (fetch_valid),
        .fetch_addr  (fetch_addr),
        .flush       (flush),
        .fetch_ready (fetch_ready),
        .rdata_valid (rdata_valid),
        .rdata       (rdata),
        .pair_ok     (pair_ok),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr),
        .mem_addr_ok (mem_addr_ok),
        .mem_data_ok (mem_data_ok),
        .mem_line    (mem_line)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // memory model
    //////////////////////////////////////////////////

    // memory content is a function of the byte address
    function automatic word_t mem_word(input word_t addr);
        return addr ^ 32'h5a5a_0000;
    endfunction

    function automatic line_t line_at(input word_t base);
        line_t line;
        for (int i = 0; i < 4; i++) begin
            line[32*i +: 32] = mem_word(base + 32'(4 * i));
        end
        return line;
    endfunction

    initial begin : memory_model
        int unsigned addr_delay;
        int unsigned data_delay;
        word_t       base;
        mem_addr_ok = 1'b0;
        mem_data_ok = 1'b0;
        mem_line    = '0;
        void'($urandom(32'h00ce_dd2d));
        forever begin
            @(posedge clk);
            if (!rst && mem_req) begin
                base       = mem_addr;
                addr_delay = $urandom % 4;
                data_delay = 1 + ($urandom % 6);
                repeat (addr_delay) @(posedge clk);
                mem_addr_ok <= 1'b1;
                @(posedge clk);
                mem_addr_ok <= 1'b0;
                repeat (data_delay - 1) @(posedge clk);
                mem_data_ok <= 1'b1;
                mem_line    <= line_at(base);
                @(posedge clk);
                mem_data_ok <= 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    task automatic load_table();
        // test, flush first, expected miss, address
        stim_table[0]  = '{3'd2, 1'b0, 1'b1, 32'h0000_1008};
        stim_table[1]  = '{3'd3, 1'b0, 1'b0, 32'h0000_1000};
        stim_table[2]  = '{3'd3, 1'b0, 1'b0, 32'h0000_1004};
        stim_table[3]  = '{3'd3, 1'b0, 1'b0, 32'h0000_1008};
        stim_table[4]  = '{3'd3, 1'b0, 1'b0, 32'h0000_100c};
        // set 5, tags A B A C A B
        stim_table[5]  = '{3'd4, 1'b0, 1'b1, 32'h0000_2050};
        stim_table[6]  = '{3'd4, 1'b0, 1'b1, 32'h0000_3054};
        stim_table[7]  = '{3'd4, 1'b0, 1'b0, 32'h0000_2058};
        stim_table[8]  = '{3'd4, 1'b0, 1'b1, 32'h0000_405c};
        stim_table[9]  = '{3'd4, 1'b0, 1'b0, 32'h0000_205c};
        stim_table[10] = '{3'd4, 1'b0, 1'b1, 32'h0000_3050};
        stim_table[11] = '{3'd5, 1'b1, 1'b1, 32'h0000_1004};
        stim_table[12] = '{3'd5, 1'b0, 1'b0, 32'h0000_100c};
        stim_table[13] = '{3'd5, 1'b0, 1'b1, 32'h0000_2050};
        stim_table[14] = '{3'd5, 1'b0, 1'b0, 32'h0000_2054};
        test_names = '{"reset and sweep", "cold miss", "hits on one line",
                       "lru replacement", "flush"};
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("Fail at %t: %s got %h expected %h", $time, name, got, exp);
        errors++;
    endtask

    // a timeout counts as an error and stops further stimulus
    task automatic flag_timeout(input string what);
        $display("Timeout: %s", what);
        timed_out = 1'b1;
        errors++;
    endtask

    task automatic end_test(input int no);
        tests_run++;
        if (errors == test_start_errs) begin
            $display("test %0d (%s) passed", no, test_names[no]);
        end else begin
            tests_failed++;
            $display("test %0d (%s) failed, %0d errors", no, test_names[no],
                     errors - test_start_errs);
        end
        test_start_errs = errors;
    endtask

    // wait for an idle cache, then pulse flush for one cycle
    task automatic flush_cache();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (fetch_ready !== 1'b1 && n < 40);
        if (fetch_ready !== 1'b1) begin
            flag_timeout("cache never idle before flush");
            return;
        end
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
    endtask

    task automatic fetch_and_check(input word_t addr, input logic exp_miss);
        int    n;
        logic  missed;
        word_t word_addr;
        logic  exp_pair;
        pair_t exp_data;
        word_addr = {addr[31:2], 2'b00};
        exp_pair  = !addr[2];
        exp_data  = {exp_pair ? mem_word(word_addr + 32'd4) : 32'd0, mem_word(word_addr)};
        fetch_valid <= 1'b1;
        fetch_addr  <= addr;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (fetch_ready !== 1'b1 && n < 40);
        fetch_valid <= 1'b0;
        if (fetch_ready !== 1'b1) begin
            flag_timeout("fetch request was not accepted");
            return;
        end
        // cycle after acceptance
        @(posedge clk);
        missed = !rdata_valid;
        if (rdata_valid !== !exp_miss) report_mismatch("rdata_valid", rdata_valid, !exp_miss);
        if (mem_req !== exp_miss) report_mismatch("mem_req", mem_req, exp_miss);
        if (fetch_ready !== !exp_miss) report_mismatch("fetch_ready", fetch_ready, !exp_miss);
        if (missed) begin
            if (mem_addr !== {addr[31:4], 4'h0}) begin
                report_mismatch("mem_addr", mem_addr, {addr[31:4], 4'h0});
            end
            n = 0;
            while (rdata_valid !== 1'b1 && n < 40) begin
                @(posedge clk);
                n++;
            end
            if (rdata_valid !== 1'b1) begin
                flag_timeout("refill data never returned");
                return;
            end
        end
        if (rdata !== exp_data) report_mismatch("rdata", rdata, exp_data);
        if (pair_ok !== exp_pair) report_mismatch("pair_ok", pair_ok, exp_pair);
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial begin : main
        int n;
        $timeformat(-9, 0, " ns", 0);
        rst             = 1'b1;
        fetch_valid     = 1'b0;
        fetch_addr      = '0;
        flush           = 1'b0;
        errors          = 0;
        test_start_errs = 0;
        tests_run       = 0;
        tests_failed    = 0;
        timed_out       = 1'b0;
        load_table();

        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        if (fetch_ready !== 1'b0) report_mismatch("fetch_ready", fetch_ready, 0);
        if (rdata_valid !== 1'b0) report_mismatch("rdata_valid", rdata_valid, 0);
        if (mem_req !== 1'b0) report_mismatch("mem_req", mem_req, 0);
        n = 0;
        while (fetch_ready !== 1'b1 && n < 20) begin
            @(posedge clk);
            n++;
        end
        if (fetch_ready !== 1'b1) flag_timeout("fetch_ready did not rise after reset");
        end_test(1);

        for (int i = 0; i < NUM_STIM && !timed_out; i++) begin
            if (stim_table[i].flush_first) flush_cache();
            if (!timed_out) begin
                fetch_and_check(stim_table[i].addr, stim_table[i].exp_miss);
            end
            if (timed_out || i == NUM_STIM - 1 ||
                stim_table[i + 1].test_no != stim_table[i].test_no) begin
                end_test(int'(stim_table[i].test_no));
            end
        end

        $display("tests run %0d, tests failed %0d, check errors %0d, assertion failures %0d",
                 tests_run, tests_failed, errors,
                 u_icache_top.u_icache_assertions.fail_count);
        if (errors == 0 && tests_failed == 0 &&
            u_icache_top.u_icache_assertions.fail_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- filelist.f
+incdir+hdl
hdl/icache_pkg.sv
hdl/icache_fill_if.sv
hdl/icache_req_buf.sv
hdl/icache_sweep_cnt.sv
hdl/icache_tag_store.sv
hdl/icache_data_store.sv
hdl/icache_lru.sv
hdl/icache_ctrl_fsm.sv
hdl/icache_top.sv
tb/icache_assertions.sv
tb/icache_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the icache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module icache_tb \
    -f filelist.f -Mdir obj_dir -o icache_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/icache_sim +verilator+error+limit+100 > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "TESTBENCH PASSED" sim.log; then
    exit 0
fi
exit 1
